/* rv_exec.f */
rv_isa_pkg.sv
exec_pkg.sv
instr_decode.sv
alu_execute.sv
result_writeback.sv
apb_issue_port.sv
rv_exec_top.sv
rv_exec_properties.sv
tb_rv_exec.sv

/* Makefile */
TOP = tb_rv_exec

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rv_exec.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f rv_exec.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@grep -q "test passed" sim.log
	@! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_rv_exec.sv */
module tb_rv_exec;
    import rv_isa_pkg::*;
    import exec_pkg::*;

    localparam word_t RESET_PC       = 32'h0000_0100;
    localparam int    TIMEOUT_CYCLES = 5000;

    typedef struct packed {
        logic        is_read;
        logic        err;
        logic [11:0] addr;
        word_t       data;
    } expect_t;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    word_t    ref_regs [32];   // Model register file
    word_t    ref_pc;
    logic     ref_illegal;
    expect_t  exp_q [$];
    int       cycles = 0;

    rv_exec_top #(
        .RESET_PC (RESET_PC)
    ) u_rv_exec_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            stop_run($sformatf("ERR %s expected %08h got %08h", name, exp, act));
    endtask

    task automatic check_status(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("ERR %s expected %h got %h", name, exp, act));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            stop_run("timeout, the run did not finish within the cycle limit");
    end

    // Checks every completed APB transfer against the queue
    always @(posedge clk) begin
        expect_t e;
        if (rst_n && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            if (exp_q.size() == 0) begin
                stop_run("an APB transfer completed with no expected result");
            end else begin
                e = exp_q.pop_front();
                check_status($sformatf("pslverr @%03h", e.addr), e.err, apb_rsp.pslverr);
                if (e.is_read && !e.err)
                    check_word($sformatf("prdata @%03h", e.addr), e.data, apb_rsp.prdata);
            end
        end
    end

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];   // Arithmetic
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Reference RV32I step on the model state
    function automatic void ref_exec(input word_t ins);
        logic [2:0] f3;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      i_imm;
        word_t      u_imm;
        word_t      b_imm;
        word_t      j_imm;
        word_t      val;
        word_t      nxt;
        logic       wr;
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        i_imm = {{20{ins[31]}}, ins[31:20]};
        u_imm = {ins[31:12], 12'b0};
        b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = ref_pc + 32'd4;
        wr    = 1'b1;
        val   = '0;
        case (ins[6:0])
            7'h13: val = alu_ref(f3, (f3 == 3'd5) && ins[30], a, i_imm);   // No SUBI
            7'h33: val = alu_ref(f3, ins[30], a, b);
            7'h37: val = u_imm;
            7'h17: val = ref_pc + u_imm;
            7'h63: begin
                wr = 1'b0;
                if (br_ref(f3, a, b))
                    nxt = ref_pc + b_imm;
            end
            7'h6f: begin
                val = ref_pc + 32'd4;
                nxt = ref_pc + j_imm;
            end
            7'h67: begin
                val = ref_pc + 32'd4;
                nxt = (a + i_imm) & ~32'h1;
            end
            default: begin
                wr          = 1'b0;
                ref_illegal = 1'b1;
            end
        endcase
        if (wr && rd != 5'd0)
            ref_regs[rd] = val;
        ref_pc = nxt;
    endfunction

    function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic reg_idx_t rand_reg();
        return 5'($urandom_range(31, 1));
    endfunction

    // Starts and ends at a falling edge and leaves the bus idle
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input word_t wdata,
                            output int waits);
        waits           = 0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(posedge clk);
        end
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input word_t data, input logic err);
        int waits;
        exp_q.push_back({1'b0, err, addr, 32'h0});
        apb_xfer(1'b1, addr, data, waits);
    endtask

    task automatic apb_read(input logic [11:0] addr, input word_t exp, input logic err,
                            output int waits);
        exp_q.push_back({1'b1, err, addr, exp});
        apb_xfer(1'b0, addr, 32'h0, waits);
    endtask

    task automatic run_instr(input word_t ins);
        int waits;
        apb_write(ADDR_INSTR, ins, 1'b0);
        ref_exec(ins);
        apb_read(ADDR_PC, ref_pc, 1'b0, waits);
        if (waits == 0)
            stop_run("the PC read right after an INSTR write was not stalled");
        apb_read(ADDR_REG_BASE + {5'b0, ins[11:7], 2'b0}, ref_regs[ins[11:7]], 1'b0, waits);
        apb_read(ADDR_STATUS, {31'b0, ref_illegal}, 1'b0, waits);
    endtask

    initial begin
        int    waits;
        word_t v;
        logic  alt;
        void'($urandom(32'hae71));
        rst_n       = 1'b0;
        apb_req     = '0;
        ref_pc      = RESET_PC;
        ref_illegal = 1'b0;
        for (int k = 0; k < 32; k++)
            ref_regs[k] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        apb_read(ADDR_PC, RESET_PC, 1'b0, waits);
        apb_read(ADDR_STATUS, 32'h0, 1'b0, waits);

        // Random operands in x1 to x8 through LUI and ADDI
        for (int k = 1; k <= 8; k++) begin
            run_instr({20'($urandom()), 5'(k), 7'h37});
            run_instr(enc_i(7'h13, 3'd0, 5'(k), 5'(k), 12'($urandom())));
        end

        for (int n = 0; n < 2; n++) begin
            for (int f = 0; f < 10; f++) begin
                alt = (f >= 8);                 // SUB and SRA
                run_instr({alt ? 7'b0100000 : 7'b0, rand_reg(), rand_reg(),
                           alt ? (f == 8 ? 3'd0 : 3'd5) : 3'(f), rand_reg(), 7'h33});
            end
            for (int f = 0; f < 9; f++) begin
                if (f == 1 || f == 5 || f == 8)
                    v = {20'b0, (f == 8) ? 7'b0100000 : 7'b0, 5'($urandom())};
                else
                    v = {20'b0, 12'($urandom())};
                run_instr(enc_i(7'h13, (f == 8) ? 3'd5 : 3'(f), rand_reg(), rand_reg(),
                                v[11:0]));
            end
        end

        // LUI and AUIPC at random PC values
        for (int n = 0; n < 3; n++) begin
            v = $urandom() & 32'hffff_fffc;
            apb_write(ADDR_PC, v, 1'b0);
            ref_pc = v;
            run_instr({20'($urandom()), rand_reg(), 7'h37});
            run_instr({20'($urandom()), rand_reg(), 7'h17});
        end

        // First round compares x3 with itself
        for (int n = 0; n < 4; n++) begin
            for (int f = 0; f < 8; f++) begin
                if (f != 2 && f != 3)
                    run_instr(enc_b(3'(f), (n == 0) ? 5'd3 : rand_reg(),
                                    (n == 0) ? 5'd3 : rand_reg(),
                                    {12'($urandom()), 1'b0}));
            end
        end
        run_instr(enc_j(rand_reg(), {20'($urandom()), 1'b0}));
        run_instr(enc_j(5'd0, {20'($urandom()), 1'b0}));
        run_instr(enc_i(7'h67, 3'd0, rand_reg(), 5'd0, 12'($urandom() | 1)));  // Odd target
        run_instr(enc_i(7'h67, 3'd0, 5'd5, 5'd5, 12'($urandom())));

        // x0 writes and illegal opcodes
        run_instr(enc_i(7'h13, 3'd0, 5'd0, 5'd1, 12'h7ff));
        run_instr(enc_i(7'h03, 3'd2, rand_reg(), rand_reg(), 12'h010));
        apb_write(ADDR_STATUS, 32'h1, 1'b0);
        ref_illegal = 1'b0;
        apb_read(ADDR_STATUS, 32'h0, 1'b0, waits);
        run_instr({7'h0, rand_reg(), rand_reg(), 3'd2, 5'd4, 7'h23});
        run_instr({25'($urandom()), 7'h7f});

        // Error responses leave the state alone
        apb_read(12'h00c, 32'h0, 1'b1, waits);
        apb_read(ADDR_INSTR, 32'h0, 1'b1, waits);
        apb_read(12'h081, 32'h0, 1'b1, waits);
        apb_write(12'h084, 32'h1234_5678, 1'b1);
        apb_write(12'h200, 32'h0, 1'b1);
        apb_read(ADDR_PC, ref_pc, 1'b0, waits);
        apb_read(ADDR_STATUS, {31'b0, ref_illegal}, 1'b0, waits);
        for (int k = 0; k < 32; k++)
            apb_read(ADDR_REG_BASE + 12'(k * 4), ref_regs[k], 1'b0, waits);

        if (exp_q.size() != 0) begin
            stop_run("expected APB responses were left unchecked");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* rv_exec_properties.sv */
module rv_exec_properties (
    input logic               clk,
    input logic               rst_n,
    input exec_pkg::apb_req_t req,
    input exec_pkg::apb_rsp_t rsp,
    input logic               issue_valid,
    input logic               busy_res
);
    import exec_pkg::*;

    // A new instruction only arrives after the last one retired
    assert property (@(posedge clk) disable iff (!rst_n)
        (req.psel && req.penable && req.pwrite && req.paddr == ADDR_INSTR)
            |-> !(issue_valid || busy_res))
        else $error("INSTR write while an instruction was in flight");

    // Host holds the request while the port stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        (req.psel && req.penable && !rsp.pready) |=> $stable(req))
        else $error("APB request changed during a stalled access");

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(issue_valid) |-> ##[1:2] !issue_valid)
        else $error("issue valid did not clear in time");

endmodule

bind apb_issue_port rv_exec_properties u_rv_exec_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .rsp         (rsp),
    .issue_valid (issue_valid),
    .busy_res    (busy_res)
);

/* rv_exec_top.sv */
module rv_exec_top #(
    parameter rv_isa_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  exec_pkg::apb_req_t apb_req,
    output exec_pkg::apb_rsp_t apb_rsp
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    issue_t     issue;
    ctrl_t      ctrl;
    ex_result_t ex_result;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    reg_idx_t   rd_idx;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      rd_data;
    word_t      pc;
    word_t      pc_wdata;
    logic       pc_wr;
    logic       status_clr;
    logic       illegal_flag;
    logic       busy_res;

    apb_issue_port u_apb_issue_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (apb_req),
        .rsp          (apb_rsp),
        .issue        (issue),
        .pc           (pc),
        .illegal_flag (illegal_flag),
        .busy_res     (busy_res),
        .rd_data      (rd_data),
        .rd_idx       (rd_idx),
        .pc_wr        (pc_wr),
        .pc_wdata     (pc_wdata),
        .status_clr   (status_clr),
        .capture      (ex_result.valid)   // Result stage loads on a valid result
    );

    instr_decode u_instr_decode (
        .issue (issue),
        .ctrl  (ctrl)
    );

    alu_execute u_alu_execute (
        .ctrl     (ctrl),
        .issue    (issue),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .result   (ex_result)
    );

    result_writeback #(
        .RESET_PC (RESET_PC)
    ) u_result_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .result       (ex_result),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data),
        .pc_wr        (pc_wr),
        .pc_wdata     (pc_wdata),
        .status_clr   (status_clr),
        .pc           (pc),
        .illegal_flag (illegal_flag),
        .busy_res     (busy_res)
    );

endmodule

/* apb_issue_port.sv */
module apb_issue_port (
    input  logic                 clk,
    input  logic                 rst_n,
    input  exec_pkg::apb_req_t   req,
    output exec_pkg::apb_rsp_t   rsp,
    output exec_pkg::issue_t     issue,
    input  rv_isa_pkg::word_t    pc,
    input  logic                 illegal_flag,
    input  logic                 busy_res,
    input  rv_isa_pkg::word_t    rd_data,
    output rv_isa_pkg::reg_idx_t rd_idx,
    output logic                 pc_wr,
    output rv_isa_pkg::word_t    pc_wdata,
    output logic                 status_clr,
    input  logic                 capture
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic   access;
    logic   hit_instr;
    logic   hit_pc;
    logic   hit_status;
    logic   hit_reg;
    logic   addr_err;
    logic   stall;
    logic   done;
    logic   wr_ok;
    logic   issue_valid;
    instr_u issue_instr;

    assign access     = req.psel & req.penable;
    assign hit_instr  = (req.paddr == ADDR_INSTR);
    assign hit_pc     = (req.paddr == ADDR_PC);
    assign hit_status = (req.paddr == ADDR_STATUS);
    assign hit_reg    = (req.paddr[11:7] == ADDR_REG_BASE[11:7]) && (req.paddr[1:0] == 2'b00);

    // INSTR is write only, the register window is read only
    assign addr_err = req.pwrite ? ~(hit_instr | hit_pc | hit_status)
                                 : ~(hit_pc | hit_status | hit_reg);

    // Hold everything but an INSTR write until the pipe drains
    assign stall = access & ~(req.pwrite & hit_instr) & (issue_valid | busy_res);
    assign done  = access & ~stall;
    assign wr_ok = done & req.pwrite & ~addr_err;

    assign rd_idx     = req.paddr[6:2];
    assign pc_wr      = wr_ok & hit_pc;
    assign pc_wdata   = req.pwdata;
    assign status_clr = wr_ok & hit_status;

    always_comb begin
        rsp.pready  = done;
        rsp.pslverr = done & addr_err;
        rsp.prdata  = '0;
        if (done && !req.pwrite && !addr_err) begin
            if (hit_pc)
                rsp.prdata = pc;
            else if (hit_status)
                rsp.prdata = {31'b0, illegal_flag};
            else
                rsp.prdata = rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            issue_valid <= 1'b0;
        else if (wr_ok && hit_instr)
            issue_valid <= 1'b1;
        else if (capture)              // Result stage took it
            issue_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (wr_ok && hit_instr)
            issue_instr <= req.pwdata;
    end

    // The PC register is stable while an instruction is in flight
    assign issue.valid = issue_valid;
    assign issue.instr = issue_instr;
    assign issue.pc    = pc;

endmodule

/* result_writeback.sv */
module result_writeback #(
    parameter rv_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  exec_pkg::ex_result_t result,
    input  rv_isa_pkg::reg_idx_t rs1_idx,
    input  rv_isa_pkg::reg_idx_t rs2_idx,
    output rv_isa_pkg::word_t    rs1_data,
    output rv_isa_pkg::word_t    rs2_data,
    input  rv_isa_pkg::reg_idx_t rd_idx,
    output rv_isa_pkg::word_t    rd_data,
    input  logic                 pc_wr,
    input  rv_isa_pkg::word_t    pc_wdata,
    input  logic                 status_clr,
    output rv_isa_pkg::word_t    pc,
    output logic                 illegal_flag,
    output logic                 busy_res
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    ex_result_t res_q;
    word_t      regs [32];
    logic       retire;

    // Result stage, payload only loads with a valid result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q.valid <= result.valid;
            if (result.valid)
                res_q <= result;
        end
    end

    assign retire   = res_q.valid;
    assign busy_res = res_q.valid;

    // Register file, x0 is never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (retire && res_q.reg_write && res_q.rd != '0) begin
            regs[res_q.rd] <= res_q.wdata;
        end
    end

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];
    assign rd_data  = regs[rd_idx];    // Host read port

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (retire)
            pc <= res_q.next_pc;
        else if (pc_wr)                // Host write, only when idle
            pc <= pc_wdata;
    end

    // Sticky until the host clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            illegal_flag <= 1'b0;
        else
            illegal_flag <= (illegal_flag & ~status_clr) | (retire & res_q.illegal);
    end

endmodule

/* alu_execute.sv */
module alu_execute (
    input  exec_pkg::ctrl_t      ctrl,
    input  exec_pkg::issue_t     issue,
    input  rv_isa_pkg::word_t    rs1_data,
    input  rv_isa_pkg::word_t    rs2_data,
    output rv_isa_pkg::reg_idx_t rs1_idx,
    output rv_isa_pkg::reg_idx_t rs2_idx,
    output exec_pkg::ex_result_t result
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      alu_res;
    word_t      pc_plus4;
    logic [4:0] shamt;
    logic       br_taken;
    logic       redirect;

    assign rs1_idx  = ctrl.rs1;
    assign rs2_idx  = ctrl.rs2;
    assign pc_plus4 = issue.pc + 32'd4;

    always_comb begin
        case (ctrl.a_sel)
            A_PC:    op_a = issue.pc;
            A_ZERO:  op_a = '0;
            default: op_a = rs1_data;
        endcase
    end

    assign op_b  = ctrl.imm_b_sel ? ctrl.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // Branch comparator always works on the register values
    always_comb begin
        case (ctrl.br_cond)
            F3_BEQ:  br_taken = (rs1_data == rs2_data);
            F3_BNE:  br_taken = (rs1_data != rs2_data);
            F3_BLT:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
            F3_BGE:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            F3_BLTU: br_taken = (rs1_data < rs2_data);
            F3_BGEU: br_taken = (rs1_data >= rs2_data);
            default: br_taken = 1'b0;   // Reserved encodings fall through
        endcase
    end

    assign redirect = ctrl.jump | (ctrl.branch & br_taken);

    always_comb begin
        result.valid     = issue.valid;
        result.reg_write = ctrl.reg_write;
        result.rd        = ctrl.rd;
        result.wdata     = (ctrl.wb_sel == WB_PC4) ? pc_plus4 : alu_res;
        // Bit 0 clear matters for JALR, other targets are already even
        result.next_pc   = redirect ? {alu_res[31:1], 1'b0} : pc_plus4;
        result.illegal   = ctrl.illegal;
    end

endmodule

/* instr_decode.sv */
module instr_decode (
    input  exec_pkg::issue_t issue,
    output exec_pkg::ctrl_t  ctrl
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    instr_u  ins;
    word_t   imm_i;
    word_t   imm_u;
    word_t   imm_b;
    word_t   imm_j;
    logic    is_r3;
    alu_op_e arith_op;

    assign ins   = issue.instr;
    assign is_r3 = (ins.r.opcode == OP_R3);

    // Immediates sign extended from the top instruction bit
    assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
    assign imm_u = {ins.u.imm31_12, 12'b0};
    assign imm_b = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11,
                    ins.b.imm10_5, ins.b.imm4_1, 1'b0};
    assign imm_j = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12,
                    ins.j.imm11, ins.j.imm10_1, 1'b0};

    // funct3 to ALU op for both OP_IMM and OP_R3
    always_comb begin
        case (ins.r.funct3)
            F3_ADD_SUB: arith_op = (is_r3 && ins.r.funct7[5]) ? ALU_SUB : ALU_ADD;  // No SUBI
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: arith_op = ins.r.funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        // Defaults give a harmless no-op
        ctrl.reg_write = 1'b0;
        ctrl.a_sel     = A_RS1;
        ctrl.imm_b_sel = 1'b0;
        ctrl.alu_op    = ALU_ADD;
        ctrl.branch    = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.wb_sel    = WB_ALU;
        ctrl.br_cond   = ins.b.funct3;
        ctrl.rd        = ins.r.rd;
        ctrl.rs1       = ins.r.rs1;
        ctrl.rs2       = ins.r.rs2;
        ctrl.imm       = imm_i;
        ctrl.illegal   = 1'b0;

        case (ins.r.opcode)
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.imm_b_sel = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            OP_R3: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.a_sel     = A_ZERO;   // 0 + imm
                ctrl.imm_b_sel = 1'b1;
                ctrl.imm       = imm_u;
            end
            OP_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.a_sel     = A_PC;
                ctrl.imm_b_sel = 1'b1;
                ctrl.imm       = imm_u;
            end
            OP_BR: begin
                // ALU forms the target and the comparator decides
                ctrl.branch    = 1'b1;
                ctrl.a_sel     = A_PC;
                ctrl.imm_b_sel = 1'b1;
                ctrl.imm       = imm_b;
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.a_sel     = A_PC;
                ctrl.imm_b_sel = 1'b1;
                ctrl.imm       = imm_j;
                ctrl.wb_sel    = WB_PC4;   // Link
            end
            OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.imm_b_sel = 1'b1;
                ctrl.wb_sel    = WB_PC4;
            end
            default: begin
                ctrl.illegal = 1'b1;       // Also loads and stores as there is no data memory
            end
        endcase
    end

endmodule

/* exec_pkg.sv */
package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;   // Operand A source

    typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;             // Writeback source

    typedef struct packed {
        logic                 reg_write;
        a_sel_e               a_sel;
        logic                 imm_b_sel;   // Operand B is imm
        alu_op_e              alu_op;
        logic                 branch;
        logic                 jump;
        wb_sel_e              wb_sel;
        logic [2:0]           br_cond;     // Branch funct3
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::word_t    imm;
        logic                 illegal;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        rv_isa_pkg::instr_u instr;
        rv_isa_pkg::word_t  pc;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        logic                 reg_write;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    wdata;
        rv_isa_pkg::word_t    next_pc;
        logic                 illegal;
    } ex_result_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [11:0]       paddr;
        rv_isa_pkg::word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        rv_isa_pkg::word_t prdata;
        logic              pslverr;
    } apb_rsp_t;

    // Register map
    localparam logic [11:0] ADDR_INSTR    = 12'h000;
    localparam logic [11:0] ADDR_PC       = 12'h004;
    localparam logic [11:0] ADDR_STATUS   = 12'h008;
    localparam logic [11:0] ADDR_REG_BASE = 12'h080;   // x0 to x31 up to 0x0FC

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes, bits 6:0
    typedef enum logic [6:0] {
        OP_IMM   = 7'b0010011,
        OP_R3    = 7'b0110011,
        OP_LD    = 7'b0000011,
        OP_ST    = 7'b0100011,
        OP_BR    = 7'b1100011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111
    } opcode_e;

    // funct3 for OP_IMM and OP_R3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for OP_BR
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        reg_idx_t    rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word, seen through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage
